// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f build.f --top-module tb_branch_predictor \
		-Mdir obj_dir -o sim_branch_predictor
	./obj_dir/sim_branch_predictor | tee sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
common/bp_pkg.sv
common/bp_lookup_if.sv
common/bp_update_if.sv
hdl/target_buffer.sv
hdl/direction_table.sv
hdl/prediction_select.sv
hdl/branch_predictor.sv
tests/tb_branch_predictor.sv

// File: common/bp_lookup_if.sv
`timescale 1ns/100ps

interface bp_lookup_if;

    bp_pkg::pc_t       pc;
    logic              hit;
    bp_pkg::bp_index_t index;
    bp_pkg::pc_t       target;

    modport buffer (
        input  pc,
        output hit,
        output index,
        output target
    );

    modport select (
        input pc,
        input hit,
        input index,
        input target
    );

endinterface

// File: common/bp_pkg.sv
package bp_pkg;

    localparam int PC_W       = 32;
    localparam int BP_ENTRIES = 8;
    localparam int IDX_W      = $clog2(BP_ENTRIES);
    localparam int TAG_W      = 21;
    // Word aligned, so the tag starts above the byte offset
    localparam int TAG_LSB    = 2;

    typedef logic [PC_W-1:0]  pc_t;
    typedef logic [TAG_W-1:0] bp_tag_t;
    typedef logic [IDX_W-1:0] bp_index_t;

    // 2-bit saturating direction counter
    typedef enum logic [1:0] {
        strong_not_taken = 2'd0,
        weak_not_taken   = 2'd1,
        weak_taken       = 2'd2,
        strong_taken     = 2'd3
    } counter_t;

    localparam counter_t INSERT_STATE = weak_taken;
    localparam counter_t RESET_STATE  = weak_not_taken;

    function automatic bp_tag_t pc_tag(input pc_t addr);
        return addr[TAG_LSB +: TAG_W];
    endfunction

    // Upper half of the counter range predicts taken
    function automatic logic counter_taken(input counter_t state);
        return (state == weak_taken) || (state == strong_taken);
    endfunction

endpackage

// File: common/bp_update_if.sv
`timescale 1ns/100ps

interface bp_update_if;

    // Resolved branch
    logic              valid;
    bp_pkg::pc_t       pc;
    logic              taken;
    bp_pkg::pc_t       target;

    // Slot decision from the target buffer
    logic              slot_hit;
    bp_pkg::bp_index_t slot_index;
    logic              insert;

    modport buffer (
        input  valid,
        input  pc,
        input  taken,
        input  target,
        output slot_hit,
        output slot_index,
        output insert
    );

    modport counters (
        input valid,
        input taken,
        input slot_hit,
        input slot_index,
        input insert
    );

endinterface

// File: hdl/branch_predictor.sv
`timescale 1ns/100ps

module branch_predictor (
    input  logic        clk,
    input  logic        rst,

    // Fetch lookup
    input  logic        fetch_valid,
    input  bp_pkg::pc_t fetch_pc,

    // Resolved branch
    input  logic        update_valid,
    input  bp_pkg::pc_t update_pc,
    input  logic        update_taken,
    input  bp_pkg::pc_t update_target,

    // Registered prediction
    output logic        pred_valid,
    output logic        pred_hit,
    output logic        pred_taken,
    output bp_pkg::pc_t pred_pc
);

    import bp_pkg::*;

    counter_t counters [BP_ENTRIES];

    bp_lookup_if lookup_bus ();
    bp_update_if update_bus ();

    assign lookup_bus.pc     = fetch_pc;
    assign update_bus.valid  = update_valid;
    assign update_bus.pc     = update_pc;
    assign update_bus.taken  = update_taken;
    assign update_bus.target = update_target;

    target_buffer u_target_buffer (
        .clk    (clk),
        .rst    (rst),
        .lookup (lookup_bus.buffer),
        .update (update_bus.buffer)
    );

    direction_table u_direction_table (
        .clk      (clk),
        .rst      (rst),
        .update   (update_bus.counters),
        .counters (counters)
    );

    prediction_select u_prediction_select (
        .clk        (clk),
        .rst        (rst),
        .lookup     (lookup_bus.select),
        .valid      (fetch_valid),
        .counters   (counters),
        .pred_valid (pred_valid),
        .pred_hit   (pred_hit),
        .pred_taken (pred_taken),
        .pred_pc    (pred_pc)
    );

endmodule

// File: hdl/direction_table.sv
`timescale 1ns/100ps

module direction_table (
    input  logic              clk,
    input  logic              rst,
    bp_update_if.counters     update,
    output bp_pkg::counter_t  counters [bp_pkg::BP_ENTRIES]
);

    import bp_pkg::*;

    counter_t hit_state;
    counter_t next_state;

    // Saturating step toward the resolved direction
    function automatic counter_t counter_step(input counter_t state, input logic taken);
        counter_t result;
        result = state;
        case (state)
            strong_not_taken: begin
                if (taken) begin
                    result = weak_not_taken;
                end
            end
            weak_not_taken: begin
                result = taken ? weak_taken : strong_not_taken;
            end
            weak_taken: begin
                result = taken ? strong_taken : weak_not_taken;
            end
            default: begin
                if (!taken) begin
                    result = weak_taken;
                end
            end
        endcase
        return result;
    endfunction

    assign hit_state  = counters[update.slot_index];
    assign next_state = counter_step(hit_state, update.taken);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BP_ENTRIES; i++) begin
                counters[i] <= RESET_STATE;
            end
        end else if (update.insert) begin
            // Shift in step with the target buffer
            for (int i = BP_ENTRIES - 1; i > 0; i--) begin
                counters[i] <= counters[i-1];
            end
            counters[0] <= INSERT_STATE;
        end else if (update.valid && update.slot_hit) begin
            counters[update.slot_index] <= next_state;
        end
    end

endmodule

// File: hdl/prediction_select.sv
`timescale 1ns/100ps

module prediction_select (
    input  logic             clk,
    input  logic             rst,
    bp_lookup_if.select      lookup,
    input  logic             valid,
    input  bp_pkg::counter_t counters [bp_pkg::BP_ENTRIES],
    output logic             pred_valid,
    output logic             pred_hit,
    output logic             pred_taken,
    output bp_pkg::pc_t      pred_pc
);

    import bp_pkg::*;

    counter_t hit_state;
    logic     taken_next;
    pc_t      pc_next;

    assign hit_state  = counters[lookup.index];
    assign taken_next = lookup.hit && counter_taken(hit_state);
    // Fall through to the next word when not taken
    assign pc_next    = taken_next ? lookup.target : lookup.pc + PC_W'(4);

    always_ff @(posedge clk) begin
        if (rst) begin
            pred_valid <= 1'b0;
            pred_hit   <= 1'b0;
            pred_taken <= 1'b0;
        end else begin
            pred_valid <= valid;
            if (valid) begin
                pred_hit   <= lookup.hit;
                pred_taken <= taken_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            pred_pc <= pc_next;
        end
    end

endmodule

// File: hdl/target_buffer.sv
`timescale 1ns/100ps

module target_buffer (
    input logic     clk,
    input logic     rst,
    bp_lookup_if.buffer lookup,
    bp_update_if.buffer update
);

    import bp_pkg::*;

    logic [BP_ENTRIES-1:0] valid_q;
    bp_tag_t               tag_q    [BP_ENTRIES];
    pc_t                   target_q [BP_ENTRIES];

    logic      lookup_hit;
    bp_index_t lookup_index;
    logic      update_hit;
    bp_index_t update_index;

    // Tags are unique among valid slots, lowest match wins anyway
    function automatic logic match_slot(input bp_tag_t tag, output bp_index_t idx);
        logic found;
        found = 1'b0;
        idx   = '0;
        for (int i = 0; i < BP_ENTRIES; i++) begin
            if (!found && valid_q[i] && (tag_q[i] == tag)) begin
                found = 1'b1;
                idx   = bp_index_t'(i);
            end
        end
        return found;
    endfunction

    always_comb begin
        lookup_hit = match_slot(pc_tag(lookup.pc), lookup_index);
        update_hit = match_slot(pc_tag(update.pc), update_index);
    end

    assign lookup.hit    = lookup_hit;
    assign lookup.index  = lookup_index;
    assign lookup.target = target_q[lookup_index];

    assign update.slot_hit   = update_hit;
    assign update.slot_index = update_index;
    // Only taken branches that miss get a slot
    assign update.insert     = update.valid && update.taken && !update_hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (update.insert) begin
            valid_q <= {valid_q[BP_ENTRIES-2:0], 1'b1};
        end
    end

    // Oldest entry falls off the top on insert
    always_ff @(posedge clk) begin
        if (update.insert) begin
            for (int i = BP_ENTRIES - 1; i > 0; i--) begin
                tag_q[i]    <= tag_q[i-1];
                target_q[i] <= target_q[i-1];
            end
            tag_q[0]    <= pc_tag(update.pc);
            target_q[0] <= update.target;
        end else if (update.valid && update.taken && update_hit) begin
            target_q[update_index] <= update.target;
        end
    end

endmodule

// File: tests/tb_branch_predictor.sv
`timescale 1ns/100ps

module tb_branch_predictor;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 120;
    localparam int RANDOM_CYCLES   = 400;
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 50;
    localparam int SLOTS           = 8;
    localparam int POOL_SIZE       = 12;

    logic        clk;
    logic        rst;
    logic        fetch_valid;
    logic [31:0] fetch_pc;
    logic        update_valid;
    logic [31:0] update_pc;
    logic        update_taken;
    logic [31:0] update_target;
    logic        pred_valid;
    logic        pred_hit;
    logic        pred_taken;
    logic [31:0] pred_pc;

    // Reference model of the buffer and counters
    logic        model_valid  [SLOTS];
    logic [20:0] model_tag    [SLOTS];
    logic [31:0] model_target [SLOTS];
    int          model_ctr    [SLOTS];

    logic        exp_hit;
    logic        exp_taken;
    logic [31:0] exp_pc;
    logic        check_q;
    logic        exp_hit_q;
    logic        exp_taken_q;
    logic [31:0] exp_pc_q;

    integer seed;
    int     lookup_count = 0;
    int     valid_errors = 0;
    int     hit_errors   = 0;
    int     taken_errors = 0;
    int     pc_errors    = 0;

    branch_predictor uut (
        .clk           (clk),
        .rst           (rst),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target),
        .pred_valid    (pred_valid),
        .pred_hit      (pred_hit),
        .pred_taken    (pred_taken),
        .pred_pc       (pred_pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Expected answer follows the lookup into the prediction register stage
    always @(posedge clk) begin
        if (rst) begin
            check_q <= 1'b0;
        end else begin
            check_q <= fetch_valid;
        end
        exp_hit_q   <= exp_hit;
        exp_taken_q <= exp_taken;
        exp_pc_q    <= exp_pc;
    end

    valid_timing: assert property (@(posedge clk) disable iff (rst) pred_valid == check_q)
        else begin
            valid_errors = valid_errors + 1;
            $display("Error at %0t: pred_valid is %0b, expected %0b", $time, pred_valid, check_q);
        end

    hit_match: assert property (@(posedge clk) disable iff (rst) check_q |-> pred_hit == exp_hit_q)
        else begin
            hit_errors = hit_errors + 1;
            $display("Error at %0t: pred_hit is %0b, expected %0b", $time, pred_hit, exp_hit_q);
        end

    taken_match: assert property (@(posedge clk) disable iff (rst)
                                  check_q |-> pred_taken == exp_taken_q)
        else begin
            taken_errors = taken_errors + 1;
            $display("Error at %0t: pred_taken is %0b, expected %0b",
                     $time, pred_taken, exp_taken_q);
        end

    pc_match: assert property (@(posedge clk) disable iff (rst) check_q |-> pred_pc == exp_pc_q)
        else begin
            pc_errors = pc_errors + 1;
            $display("Error at %0t: pred_pc is %h, expected %h", $time, pred_pc, exp_pc_q);
        end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    // Lowest valid slot whose tag matches, or -1
    function automatic int find_slot(input logic [31:0] pc);
        int slot;
        slot = -1;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (model_valid[i] && model_tag[i] == pc[22:2]) begin
                slot = i;
            end
        end
        return slot;
    endfunction

    task automatic predict(input logic [31:0] pc);
        int slot;
        slot = find_slot(pc);
        exp_hit   = 1'b0;
        exp_taken = 1'b0;
        exp_pc    = pc + 32'd4;
        if (slot >= 0) begin
            exp_hit = 1'b1;
            if (model_ctr[slot] >= 2) begin
                exp_taken = 1'b1;
                exp_pc    = model_target[slot];
            end
        end
    endtask

    task automatic train(input logic [31:0] pc, input logic taken, input logic [31:0] target);
        int slot;
        slot = find_slot(pc);
        if (slot >= 0) begin
            if (taken) begin
                model_target[slot] = target;
                if (model_ctr[slot] < 3) model_ctr[slot] = model_ctr[slot] + 1;
            end else if (model_ctr[slot] > 0) begin
                model_ctr[slot] = model_ctr[slot] - 1;
            end
        end else if (taken) begin
            for (int i = SLOTS - 1; i > 0; i--) begin
                model_valid[i]  = model_valid[i-1];
                model_tag[i]    = model_tag[i-1];
                model_target[i] = model_target[i-1];
                model_ctr[i]    = model_ctr[i-1];
            end
            model_valid[0]  = 1'b1;
            model_tag[0]    = pc[22:2];
            model_target[0] = target;
            model_ctr[0]    = 2;
        end
    endtask

    // One cycle of stimulus; the lookup sees the model before the update
    task automatic step_cycle(input logic fv, input logic [31:0] fpc, input logic uv,
                              input logic [31:0] upc, input logic ut, input logic [31:0] utgt);
        @(negedge clk);
        fetch_valid   = fv;
        fetch_pc      = fpc;
        update_valid  = uv;
        update_pc     = upc;
        update_taken  = ut;
        update_target = utgt;
        if (fv) begin
            predict(fpc);
            lookup_count = lookup_count + 1;
        end
        if (uv) train(upc, ut, utgt);
    endtask

    task automatic lookup_pc(input logic [31:0] pc);
        step_cycle(1'b1, pc, 1'b0, 32'd0, 1'b0, 32'd0);
    endtask

    task automatic resolve_branch(input logic [31:0] pc, input logic taken,
                                  input logic [31:0] target);
        step_cycle(1'b0, 32'd0, 1'b1, pc, taken, target);
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) step_cycle(1'b0, 32'd0, 1'b0, 32'd0, 1'b0, 32'd0);
    endtask

    initial begin
        logic [31:0] pool [POOL_SIZE];
        logic [31:0] r;
        logic [31:0] t;
        logic [31:0] lookup_addr;
        int          pick;

        seed          = 32'h73ad;
        rst           = 1'b1;
        fetch_valid   = 1'b0;
        fetch_pc      = 32'd0;
        update_valid  = 1'b0;
        update_pc     = 32'd0;
        update_taken  = 1'b0;
        update_target = 32'd0;
        exp_hit       = 1'b0;
        exp_taken     = 1'b0;
        exp_pc        = 32'd0;
        for (int i = 0; i < SLOTS; i++) begin
            model_valid[i]  = 1'b0;
            model_tag[i]    = '0;
            model_target[i] = '0;
            model_ctr[i]    = 1;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Empty tables miss everywhere
        lookup_pc(32'h0000_1000);
        idle_cycles(2);
        lookup_pc(32'h0000_2004);
        lookup_pc(32'h8000_0ffc);
        lookup_pc(32'h0000_1000);

        // Install, then retarget with a lookup in the same cycle
        resolve_branch(32'h0000_1100, 1'b1, 32'h0000_8000);
        lookup_pc(32'h0000_1100);
        step_cycle(1'b1, 32'h0000_1100, 1'b1, 32'h0000_1100, 1'b1, 32'h0000_9000);
        lookup_pc(32'h0000_1100);

        // Not-taken miss leaves no entry
        resolve_branch(32'h0000_1200, 1'b0, 32'h0000_a000);
        lookup_pc(32'h0000_1200);
        idle_cycles(1);
        lookup_pc(32'h0000_1200);

        // Counter walk with saturation at both ends
        resolve_branch(32'h0000_1300, 1'b1, 32'h0000_b000);
        resolve_branch(32'h0000_1300, 1'b0, 32'h0000_b000);
        lookup_pc(32'h0000_1300);
        repeat (3) resolve_branch(32'h0000_1300, 1'b1, 32'h0000_b000);
        lookup_pc(32'h0000_1300);
        resolve_branch(32'h0000_1300, 1'b0, 32'h0000_b000);
        lookup_pc(32'h0000_1300);
        resolve_branch(32'h0000_1300, 1'b0, 32'h0000_b000);
        lookup_pc(32'h0000_1300);
        repeat (3) resolve_branch(32'h0000_1300, 1'b0, 32'h0000_b000);
        resolve_branch(32'h0000_1300, 1'b1, 32'h0000_b000);
        lookup_pc(32'h0000_1300);

        // Nine installs push the first one out
        for (int i = 0; i < 9; i++) begin
            resolve_branch(32'h0001_0000 + i * 16, 1'b1, 32'h0002_0000 + i * 256);
        end
        for (int i = 0; i < 9; i++) begin
            lookup_pc(32'h0001_0000 + i * 16);
        end
        idle_cycles(2);

        for (int i = 0; i < POOL_SIZE; i++) begin
            pool[i] = 32'h0000_4000 + i * 64;
        end
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            r           = $random(seed);
            t           = $random(seed);
            pick        = $unsigned(t) % POOL_SIZE;
            lookup_addr = pool[pick];
            // Control bits stay out of the update pick
            pick        = $unsigned(r >> 3) % POOL_SIZE;
            step_cycle(r[0], lookup_addr, r[1], pool[pick], r[2], t & 32'hffff_fffc);
        end
        idle_cycles(3);

        $display("Lookups checked: %0d, errors: valid %0d, hit %0d, taken %0d, pc %0d",
                 lookup_count, valid_errors, hit_errors, taken_errors, pc_errors);
        if (valid_errors + hit_errors + taken_errors + pc_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
